/* design/cmdFetch.sv */
`timescale 1ns/100ps

module cmdFetch (
    input  logic                                                  BRAM_clk,
    input  logic                                                  rstN,
    input  logic                                                  start,
    output logic                                                  busy,
    output logic                                                  done,
    output logic [gfxCmdPkg::MEM_AW-1:0]                          headAddr,
    input  gfxCmdPkg::cmdWord_u                                   headWord,
    output logic [gfxCmdPkg::MEM_AW-1:0]                          operandAddr,
    input  gfxCmdPkg::cmdWord_u [gfxCmdPkg::OPERANDS_PER_BEAT-1:0] operandWords,
    output gfxCmdPkg::cmdBeat_s                                   beat,
    output logic                                                  beatValid,
    input  logic                                                  beatReady
);

    typedef enum logic [1:0] {
        stIdle,
        stHeader,
        stOperands,
        stFinish
    } fetchState_e;

    fetchState_e                  state;
    logic [gfxCmdPkg::MEM_AW-1:0] pc;         // program counter, word address
    logic [7:0]                   opcode;     // latched from header
    logic [7:0]                   param;
    logic [7:0]                   remaining;  // operands not yet sent
    logic [1:0]                   beatIdx;

    gfxCmdPkg::cmdHeader_s        head;
    logic                         known;
    logic                         lastBeat;
    logic [2:0]                   count;
    logic [gfxCmdPkg::MEM_AW-1:0] countStep;
    logic [gfxCmdPkg::MEM_AW-1:0] skipLen;
    logic                         beatFire;

    ////////////////////////////////////////
    // header decode
    ////////////////////////////////////////

    assign head  = headWord.header;
    assign known = head.opcode inside {gfxCmdPkg::OP_MATRIX_MODE, gfxCmdPkg::OP_LOAD_MATRIX,
                                       gfxCmdPkg::OP_VERTEX, gfxCmdPkg::OP_COLOR};

    // operands to step over for an unknown opcode
    assign skipLen = head.longForm ? head.param[gfxCmdPkg::MEM_AW-1:0] : '0;

    // both read ports follow the program counter
    assign headAddr    = pc;
    assign operandAddr = pc;

    ////////////////////////////////////////
    // beat build
    ////////////////////////////////////////

    assign lastBeat  = remaining <= gfxCmdPkg::OPERANDS_PER_BEAT;
    assign count     = lastBeat ? remaining[2:0] : 3'(gfxCmdPkg::OPERANDS_PER_BEAT);
    assign countStep = {{(gfxCmdPkg::MEM_AW-3){1'b0}}, count};

    always_comb begin
        beat         = '0;
        beat.opcode  = opcode;
        beat.param   = param;
        beat.beatIdx = beatIdx;
        beat.last    = lastBeat;
        beat.count   = count;
        for (int i = 0; i < gfxCmdPkg::OPERANDS_PER_BEAT; i++) begin
            if (i < count) begin
                beat.operands[i] = operandWords[i];  // slots past count stay zero
            end
        end
    end

    assign beatValid = (state == stOperands);
    assign beatFire  = beatValid && beatReady;
    assign busy      = (state == stHeader) || (state == stOperands);
    assign done      = (state == stFinish);

    ////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (!rstN) begin
            state     <= stIdle;
            pc        <= '0;
            remaining <= '0;
            beatIdx   <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state <= stHeader;
                        pc    <= '0;  // every list starts at word 0
                    end
                end
                stHeader: begin
                    if (head.opcode == gfxCmdPkg::OP_END) begin
                        state <= stFinish;
                    end else if (!known) begin
                        pc <= pc + skipLen + 1'b1;  // no beats for this one
                    end else begin
                        opcode    <= head.opcode;
                        param     <= head.param;
                        beatIdx   <= '0;
                        remaining <= head.longForm ? head.param : 8'd0;
                        pc        <= pc + 1'b1;
                        state     <= stOperands;
                    end
                end
                stOperands: begin
                    if (beatFire) begin  // held while render state stalls
                        pc        <= pc + countStep;
                        remaining <= remaining - {5'b0, count};
                        beatIdx   <= beatIdx + 1'b1;
                        if (lastBeat) begin
                            state <= stHeader;
                        end
                    end
                end
                default: begin
                    state <= stIdle;  // finish lasts one cycle
                end
            endcase
        end
    end

endmodule

/* design/cmdMemory.sv */
`timescale 1ns/100ps

module cmdMemory (
    input  logic                                                  BRAM_clk,
    input  logic                                                  BRAM_en,
    input  logic [3:0]                                            BRAM_wen,
    input  logic [31:0]                                           BRAM_addr,
    input  logic [31:0]                                           BRAM_dout,
    output logic [31:0]                                           BRAM_din,
    input  logic [gfxCmdPkg::MEM_AW-1:0]                          headAddr,
    output gfxCmdPkg::cmdWord_u                                   headWord,
    input  logic [gfxCmdPkg::MEM_AW-1:0]                          operandAddr,
    output gfxCmdPkg::cmdWord_u [gfxCmdPkg::OPERANDS_PER_BEAT-1:0] operandWords
);

    logic [gfxCmdPkg::WORD_W-1:0] mem [gfxCmdPkg::MEM_DEPTH];
    logic [gfxCmdPkg::MEM_AW-1:0] hostAddr;

    // byte address bits 8:2 pick the word
    assign hostAddr = BRAM_addr[gfxCmdPkg::HOST_WORD_LSB +: gfxCmdPkg::MEM_AW];

    ////////////////////////////////////////
    // host write, byte lanes
    ////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (BRAM_en) begin
            for (int b = 0; b < 4; b++) begin
                if (BRAM_wen[b]) begin  // wen[3] is bits 31:24
                    mem[hostAddr][8*b +: 8] <= BRAM_dout[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // combinational reads
    ////////////////////////////////////////

    assign BRAM_din = mem[hostAddr];
    assign headWord = mem[headAddr];

    // four consecutive words, address wraps at the top
    always_comb begin
        logic [gfxCmdPkg::MEM_AW-1:0] wordAddr;
        for (int i = 0; i < gfxCmdPkg::OPERANDS_PER_BEAT; i++) begin
            wordAddr        = operandAddr + i[gfxCmdPkg::MEM_AW-1:0];
            operandWords[i] = mem[wordAddr];
        end
    end

endmodule

/* design/gfxCmdPkg.sv */
package gfxCmdPkg;

    ////////////////////////////////////////
    // command memory geometry
    ////////////////////////////////////////

    localparam int MEM_DEPTH         = 128;  // words
    localparam int MEM_AW            = 7;    // word address width
    localparam int WORD_W            = 32;
    localparam int OPERANDS_PER_BEAT = 4;    // wide read port size
    localparam int HOST_WORD_LSB     = 2;    // host port is byte addressed

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////

    localparam logic [7:0] OP_END         = 8'h00;  // short form
    localparam logic [7:0] OP_MATRIX_MODE = 8'h10;  // short form, param picks matrix
    localparam logic [7:0] OP_LOAD_MATRIX = 8'h11;  // long form, 16 words row-major
    localparam logic [7:0] OP_VERTEX      = 8'h03;  // long form, x y z
    localparam logic [7:0] OP_COLOR       = 8'h04;  // long form, r g b

    ////////////////////////////////////////
    // command words
    ////////////////////////////////////////

    // header layout, msb first
    typedef struct packed {
        logic        longForm;  // operands follow
        logic [14:0] reserved;
        logic [7:0]  param;     // operand count or immediate
        logic [7:0]  opcode;
    } cmdHeader_s;

    // a fetched word means a header or an operand
    // depending on where it sits in the list
    typedef union packed {
        cmdHeader_s        header;
        logic [WORD_W-1:0] operand;  // raw ieee single
    } cmdWord_u;

    ////////////////////////////////////////
    // fetch to render state beat
    ////////////////////////////////////////

    typedef struct packed {
        logic [7:0]                       opcode;
        logic [7:0]                       param;
        logic [1:0]                       beatIdx;  // beat number within command
        logic                             last;
        logic [2:0]                       count;    // valid operands, 0..4
        cmdWord_u [OPERANDS_PER_BEAT-1:0] operands; // operands[0] is lowest address
    } cmdBeat_s;

endpackage

/* design/gfxCmdUnit.sv */
`timescale 1ns/100ps

module gfxCmdUnit (
    input  logic                    BRAM_clk,
    input  logic                    rstN,
    // host port
    input  logic                    BRAM_en,
    input  logic [3:0]              BRAM_wen,
    input  logic [31:0]             BRAM_addr,
    input  logic [31:0]             BRAM_dout,
    output logic [31:0]             BRAM_din,
    // control
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    // vertex stream
    output gfxGeomPkg::vertex_s     vertexOut,
    output logic                    vertexValid,
    input  logic                    vertexReady,
    // render state
    output gfxGeomPkg::matrixMode_e matrixMode,
    output gfxGeomPkg::matrix_s     modelviewMatrix,
    output gfxGeomPkg::matrix_s     projectionMatrix
);

    logic [gfxCmdPkg::MEM_AW-1:0]                          headAddr;
    gfxCmdPkg::cmdWord_u                                   headWord;
    logic [gfxCmdPkg::MEM_AW-1:0]                          operandAddr;
    gfxCmdPkg::cmdWord_u [gfxCmdPkg::OPERANDS_PER_BEAT-1:0] operandWords;
    gfxCmdPkg::cmdBeat_s                                   beat;
    logic                                                  beatValid;
    logic                                                  beatReady;

    ////////////////////////////////////////
    // command memory
    ////////////////////////////////////////

    cmdMemory uMemory (
        .BRAM_clk     (BRAM_clk),
        .BRAM_en      (BRAM_en),
        .BRAM_wen     (BRAM_wen),
        .BRAM_addr    (BRAM_addr),
        .BRAM_dout    (BRAM_dout),
        .BRAM_din     (BRAM_din),
        .headAddr     (headAddr),
        .headWord     (headWord),
        .operandAddr  (operandAddr),
        .operandWords (operandWords)
    );

    ////////////////////////////////////////
    // fetch and render state
    ////////////////////////////////////////

    cmdFetch uFetch (
        .BRAM_clk     (BRAM_clk),
        .rstN         (rstN),
        .start        (start),
        .busy         (busy),
        .done         (done),
        .headAddr     (headAddr),
        .headWord     (headWord),
        .operandAddr  (operandAddr),
        .operandWords (operandWords),
        .beat         (beat),
        .beatValid    (beatValid),
        .beatReady    (beatReady)
    );

    renderState uState (
        .BRAM_clk         (BRAM_clk),
        .rstN             (rstN),
        .beat             (beat),
        .beatValid        (beatValid),
        .beatReady        (beatReady),
        .vertexOut        (vertexOut),
        .vertexValid      (vertexValid),
        .vertexReady      (vertexReady),
        .matrixMode       (matrixMode),
        .modelviewMatrix  (modelviewMatrix),
        .projectionMatrix (projectionMatrix)
    );

endmodule

/* design/gfxGeomPkg.sv */
package gfxGeomPkg;

    ////////////////////////////////////////
    // geometry sizes
    ////////////////////////////////////////

    localparam int COMP_W  = 32;  // one ieee single
    localparam int MAT_DIM = 4;

    ////////////////////////////////////////
    // render types
    ////////////////////////////////////////

    typedef struct packed {
        logic [COMP_W-1:0] r;
        logic [COMP_W-1:0] g;
        logic [COMP_W-1:0] b;
    } color_s;

    // one emitted vertex, tagged with the colour in force
    typedef struct packed {
        logic [COMP_W-1:0] x;
        logic [COMP_W-1:0] y;
        logic [COMP_W-1:0] z;
        color_s            color;
    } vertex_s;

    typedef enum logic {
        MODELVIEW  = 1'b0,
        PROJECTION = 1'b1
    } matrixMode_e;

    // elem[row][col], row-major as loaded from the list
    typedef struct packed {
        logic [MAT_DIM-1:0][MAT_DIM-1:0][COMP_W-1:0] elem;
    } matrix_s;

endpackage

/* design/renderState.sv */
`timescale 1ns/100ps

module renderState (
    input  logic                    BRAM_clk,
    input  logic                    rstN,
    input  gfxCmdPkg::cmdBeat_s     beat,
    input  logic                    beatValid,
    output logic                    beatReady,
    output gfxGeomPkg::vertex_s     vertexOut,
    output logic                    vertexValid,
    input  logic                    vertexReady,
    output gfxGeomPkg::matrixMode_e matrixMode,
    output gfxGeomPkg::matrix_s     modelviewMatrix,
    output gfxGeomPkg::matrix_s     projectionMatrix
);

    gfxGeomPkg::color_s curColor;
    logic               vertexStall;
    logic               beatFire;
    logic               vertexCapture;
    logic               vertexLoad;

    ////////////////////////////////////////
    // beat handshake
    ////////////////////////////////////////

    assign vertexStall = vertexValid && !vertexReady;
    assign beatReady   = !vertexStall;  // stall only while a vertex waits
    assign beatFire    = beatValid && beatReady;

    assign vertexCapture = beatFire && (beat.opcode == gfxCmdPkg::OP_VERTEX)
                           && (beat.beatIdx == 2'd0);
    assign vertexLoad    = beatFire && (beat.opcode == gfxCmdPkg::OP_VERTEX) && beat.last;

    ////////////////////////////////////////
    // vertex output register
    ////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (vertexCapture) begin
            vertexOut.x     <= beat.operands[0].operand;
            vertexOut.y     <= beat.operands[1].operand;
            vertexOut.z     <= beat.operands[2].operand;
            vertexOut.color <= curColor;  // colour in force at this vertex
        end
    end

    ////////////////////////////////////////
    // render state registers
    ////////////////////////////////////////

    always_ff @(posedge BRAM_clk) begin
        if (!rstN) begin
            vertexValid      <= 1'b0;
            curColor         <= '0;
            matrixMode       <= gfxGeomPkg::MODELVIEW;
            modelviewMatrix  <= '0;
            projectionMatrix <= '0;
        end else begin
            // a new vertex may replace one leaving this cycle
            if (vertexLoad) begin
                vertexValid <= 1'b1;
            end else if (vertexReady) begin
                vertexValid <= 1'b0;
            end

            if (beatFire) begin
                case (beat.opcode)
                    gfxCmdPkg::OP_COLOR: begin
                        if (beat.beatIdx == 2'd0) begin
                            curColor.r <= beat.operands[0].operand;
                            curColor.g <= beat.operands[1].operand;
                            curColor.b <= beat.operands[2].operand;
                        end
                    end
                    gfxCmdPkg::OP_MATRIX_MODE: begin
                        matrixMode <= gfxGeomPkg::matrixMode_e'(beat.param[0]);
                    end
                    gfxCmdPkg::OP_LOAD_MATRIX: begin
                        // one row per beat
                        for (int c = 0; c < gfxGeomPkg::MAT_DIM; c++) begin
                            if (c < beat.count) begin
                                if (matrixMode == gfxGeomPkg::PROJECTION) begin
                                    projectionMatrix.elem[beat.beatIdx][c] <=
                                        beat.operands[c].operand;
                                end else begin
                                    modelviewMatrix.elem[beat.beatIdx][c] <=
                                        beat.operands[c].operand;
                                end
                            end
                        end
                    end
                    default: begin
                        // vertex beats go to the output register
                    end
                endcase
            end
        end
    end

endmodule

/* sources.f */
+incdir+verification
design/gfxCmdPkg.sv
design/gfxGeomPkg.sv
design/cmdMemory.sv
design/cmdFetch.sv
design/renderState.sv
design/gfxCmdUnit.sv
verification/gfxCmdUnitTb.sv

/* verification/gfxCmdTests.svh */
////////////////////////////////////////
// list building
////////////////////////////////////////

function automatic logic [31:0] cmdHeader(input logic longForm, input logic [7:0] param,
                                          input logic [7:0] opcode);
    return {longForm, 15'd0, param, opcode};
endfunction

function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                           input logic [3:0] wen);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++) begin
        if (wen[b]) begin
            result[8*b +: 8] = data[8*b +: 8];
        end
    end
    return result;
endfunction

task automatic addColor(input logic [31:0] r, input logic [31:0] g, input logic [31:0] b);
    listWords.push_back(cmdHeader(1'b1, 8'd3, gfxCmdPkg::OP_COLOR));
    listWords.push_back(r);
    listWords.push_back(g);
    listWords.push_back(b);
    listColor = '{r: r, g: g, b: b};
endtask

task automatic addVertex(input logic [31:0] x, input logic [31:0] y, input logic [31:0] z);
    listWords.push_back(cmdHeader(1'b1, 8'd3, gfxCmdPkg::OP_VERTEX));
    listWords.push_back(x);
    listWords.push_back(y);
    listWords.push_back(z);
    expVertices.push_back('{x: x, y: y, z: z, color: listColor});
endtask

// unknown long-form command, operands are junk
task automatic addSkip(input logic [7:0] opcode, input int words);
    listWords.push_back(cmdHeader(1'b1, 8'(words), opcode));
    repeat (words) listWords.push_back($urandom);
endtask

task automatic loadList();
    listWords.push_back(cmdHeader(1'b0, 8'd0, gfxCmdPkg::OP_END));
    for (int i = 0; i < listWords.size(); i++) begin
        hostWrite(i, listWords[i], 4'hF);
    end
endtask

// three coloured vertices, 1.0 = 3f800000 and -1.0 = bf800000
task automatic buildReference(input logic withSkips);
    listWords.delete();
    expVertices.delete();
    addColor(32'h3f800000, 32'h0, 32'h0);
    if (withSkips) addSkip(8'h7e, 5);
    addVertex(32'hbf800000, 32'hbf800000, 32'h0);
    addColor(32'h0, 32'h3f800000, 32'h0);
    addVertex(32'h3f800000, 32'hbf800000, 32'h0);
    if (withSkips) addSkip(8'h55, 2);
    addColor(32'h0, 32'h0, 32'h3f800000);
    addVertex(32'h0, 32'h3f800000, 32'h0);
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic resetStateTest();
    checkValue({busy, done, vertexValid}, 3'b000, "control after reset");
    checkValue(matrixMode, gfxGeomPkg::MODELVIEW, "mode after reset");
    checkValue(modelviewMatrix, '0, "modelview after reset");
    checkValue(projectionMatrix, '0, "projection after reset");
endtask

task automatic hostPortTest();
    logic [31:0] expected;
    logic [31:0] data;
    logic [31:0] readBack;
    logic [3:0]  wen;
    for (int i = 0; i < 8; i++) begin
        expected = $urandom;
        hostWrite(96 + i, expected, 4'hF);
        hostRead(96 + i, readBack);
        checkValue(readBack, expected, $sformatf("host word %0d full", 96 + i));
        for (int k = 0; k < 4; k++) begin
            data = $urandom;
            wen  = 4'($urandom);
            hostWrite(96 + i, data, wen);
            expected = mergeBytes(expected, data, wen);
            hostRead(96 + i, readBack);
            checkValue(readBack, expected, $sformatf("host word %0d wen %b", 96 + i, wen));
        end
    end
endtask

task automatic referenceProgramTest();
    buildReference(1'b0);
    loadList();
    runList();
endtask

task automatic matrixLoadTest();
    logic [31:0] projWords [16];
    logic [31:0] viewWords [16];
    listWords.delete();
    expVertices.delete();
    for (int i = 0; i < 16; i++) begin
        projWords[i] = $urandom;
        viewWords[i] = $urandom;
    end
    listWords.push_back(cmdHeader(1'b0, 8'd1, gfxCmdPkg::OP_MATRIX_MODE));
    listWords.push_back(cmdHeader(1'b1, 8'd16, gfxCmdPkg::OP_LOAD_MATRIX));
    for (int i = 0; i < 16; i++) listWords.push_back(projWords[i]);
    listWords.push_back(cmdHeader(1'b0, 8'd0, gfxCmdPkg::OP_MATRIX_MODE));
    listWords.push_back(cmdHeader(1'b1, 8'd16, gfxCmdPkg::OP_LOAD_MATRIX));
    for (int i = 0; i < 16; i++) listWords.push_back(viewWords[i]);
    loadList();
    runList();
    checkValue(matrixMode, gfxGeomPkg::MODELVIEW, "mode after second load");
    for (int r = 0; r < 4; r++) begin  // row-major, word 4r+c
        for (int c = 0; c < 4; c++) begin
            checkValue(projectionMatrix.elem[r][c], projWords[4*r + c],
                       $sformatf("projection[%0d][%0d]", r, c));
            checkValue(modelviewMatrix.elem[r][c], viewWords[4*r + c],
                       $sformatf("modelview[%0d][%0d]", r, c));
        end
    end
endtask

task automatic backPressureTest();
    listWords.delete();
    expVertices.delete();
    addColor($urandom, $urandom, $urandom);
    for (int i = 0; i < 12; i++) begin
        if (i == 6) addColor($urandom, $urandom, $urandom);
        addVertex($urandom, $urandom, $urandom);
    end
    loadList();
    backPressure = 1'b1;
    runList();
endtask

task automatic skipUnknownTest();
    buildReference(1'b1);
    loadList();
    runList();
endtask

/* verification/gfxCmdUnitTb.sv */
`timescale 1ns/100ps

module gfxCmdUnitTb;

    localparam int maxCycles = 4000;  // all tests together stay under 1500

    logic                    BRAM_clk;
    logic                    rstN;
    logic                    BRAM_en;
    logic [3:0]              BRAM_wen;
    logic [31:0]             BRAM_addr;
    logic [31:0]             BRAM_dout;
    logic [31:0]             BRAM_din;
    logic                    start;
    logic                    busy;
    logic                    done;
    gfxGeomPkg::vertex_s     vertexOut;
    logic                    vertexValid;
    logic                    vertexReady;
    gfxGeomPkg::matrixMode_e matrixMode;
    gfxGeomPkg::matrix_s     modelviewMatrix;
    gfxGeomPkg::matrix_s     projectionMatrix;

    int                  errorCount   = 0;
    int                  checkCount   = 0;
    int                  cycleCount   = 0;
    int                  doneCount    = 0;
    int                  stretchLeft  = 0;
    logic                backPressure = 1'b0;
    logic [31:0]         listWords [$];     // command list image, word 0 first
    gfxGeomPkg::vertex_s expVertices [$];
    gfxGeomPkg::vertex_s gotVertices [$];
    gfxGeomPkg::color_s  listColor = '0;    // colour in force after the list so far

    gfxCmdUnit DUT (.*);

    always #10 BRAM_clk = ~BRAM_clk;

    ////////////////////////////////////////
    // monitors
    ////////////////////////////////////////

    always @(posedge BRAM_clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Timeout after %0d cycles, a test never finished", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(negedge BRAM_clk) begin
        if (done === 1'b1) begin
            doneCount++;
        end
        if (vertexValid === 1'b1 && vertexReady === 1'b1) begin
            gotVertices.push_back(vertexOut);  // transfers at the next edge
        end
    end

    // random ready stretches while back-pressure is on
    always @(posedge BRAM_clk) begin
        if (!backPressure) begin
            vertexReady <= 1'b1;
        end else if (stretchLeft == 0) begin
            vertexReady <= 1'($urandom % 2);
            stretchLeft = 1 + $urandom % 6;
        end else begin
            stretchLeft--;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic checkValue(input logic [511:0] actual, input logic [511:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic hostWrite(input int wordAddr, input logic [31:0] data, input logic [3:0] wen);
        @(posedge BRAM_clk);
        BRAM_en   <= 1'b1;
        BRAM_wen  <= wen;
        BRAM_addr <= 32'(wordAddr) << 2;
        BRAM_dout <= data;
        @(posedge BRAM_clk);
        BRAM_en  <= 1'b0;  // write lands on this edge
        BRAM_wen <= 4'h0;
    endtask

    task automatic hostRead(input int wordAddr, output logic [31:0] data);
        @(posedge BRAM_clk);
        BRAM_addr <= 32'(wordAddr) << 2;
        @(negedge BRAM_clk);
        data = BRAM_din;
    endtask

    task automatic startAndWait();
        @(posedge BRAM_clk);
        start <= 1'b1;
        @(posedge BRAM_clk);
        start <= 1'b0;
        @(negedge BRAM_clk);
        checkValue(busy, 1'b1, "busy after start");
        while (done !== 1'b1) begin
            @(negedge BRAM_clk);
        end
        checkValue(busy, 1'b0, "busy while done");
        @(negedge BRAM_clk);
        checkValue(done, 1'b0, "done after one cycle");
    endtask

    task automatic runList();
        int doneBefore;
        doneBefore = doneCount;
        gotVertices.delete();
        startAndWait();
        backPressure = 1'b0;  // let a held vertex drain
        do begin
            @(negedge BRAM_clk);
        end while (vertexValid === 1'b1);
        @(posedge BRAM_clk);  // monitors have seen the last negedge
        checkValue(doneCount - doneBefore, 1, "done pulses per run");
        checkValue(gotVertices.size(), expVertices.size(), "vertex count");
        for (int i = 0; i < expVertices.size() && i < gotVertices.size(); i++) begin
            checkValue(gotVertices[i], expVertices[i], $sformatf("vertex %0d", i));
        end
    endtask

    `include "gfxCmdTests.svh"

    initial begin
        void'($urandom(32'h90806771));
        BRAM_clk    = 1'b0;
        rstN        = 1'b0;
        BRAM_en     = 1'b0;
        BRAM_wen    = 4'h0;
        BRAM_addr   = '0;
        BRAM_dout   = '0;
        start       = 1'b0;
        vertexReady = 1'b1;
        repeat (4) @(posedge BRAM_clk);
        rstN <= 1'b1;
        @(negedge BRAM_clk);
        resetStateTest();  // must come first
        hostPortTest();
        referenceProgramTest();
        matrixLoadTest();
        backPressureTest();
        skipUnknownTest();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
